// ==== include/backend_cfg.svh ====
`ifndef BACKEND_CFG_SVH
`define BACKEND_CFG_SVH

// --------------------------------------------------
// backend sizing
// --------------------------------------------------

// datapath word width in bits
`define BE_XLEN 16

// integer registers, r0 included
`define BE_REG_NUM 8

// reorder buffer entries
`define BE_ROB_DEPTH 4

// alu pipeline stages
`define BE_ALU_LAT 2

`endif

// ==== rtl/instr_pkg.sv ====
`default_nettype none

`include "backend_cfg.svh"

package instr_pkg;

  // operand or result value
  typedef logic [`BE_XLEN-1:0] word_t;

  // architectural register index
  typedef logic [$clog2(`BE_REG_NUM)-1:0] reg_idx_t;

  // alu operation codes
  // addi takes the immediate in place of rs2
  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_AND  = 3'd2,
    ALU_OR   = 3'd3,
    ALU_XOR  = 3'd4,
    ALU_ADDI = 3'd5
  } alu_op_t;

endpackage

`default_nettype wire

// ==== rtl/rob_pkg.sv ====
`default_nettype none

`include "backend_cfg.svh"

package rob_pkg;

  // rob entry tag, also the renaming tag
  typedef logic [$clog2(`BE_ROB_DEPTH)-1:0] rob_idx_t;

  // issue controller states
  typedef enum logic [1:0] {
    // waiting for a new instruction
    ST_IDLE          = 2'd0,
    // at least one source still in flight
    ST_WAIT_OPERANDS = 2'd1,
    // one-cycle send to the alu
    ST_DISPATCH      = 2'd2
  } issue_state_t;

endpackage

`default_nettype wire

// ==== rtl/commit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface commit_if ();
  import instr_pkg::*;
  import rob_pkg::*;

  // one pulse per retired entry
  logic     valid;
  // destination register
  reg_idx_t rd;
  // result to write back
  word_t    value;
  // tag of the retiring entry
  rob_idx_t tag;

  // rob side drives the write
  modport rob (output valid, output rd, output value, output tag);

  // register side always takes it
  modport regs (input valid, input rd, input value, input tag);

endinterface

`default_nettype wire

// ==== rtl/rob_ptr_ctr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_cfg.svh"

module rob_ptr_ctr (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              alloc_i,
  input  logic              retire_i,
  output rob_pkg::rob_idx_t head_o,
  output rob_pkg::rob_idx_t tail_o,
  output logic              full_o,
  output logic              empty_o
);
  import rob_pkg::*;

  // one extra bit so a full rob is representable
  localparam int CNT_W = $clog2(`BE_ROB_DEPTH) + 1;
  localparam rob_idx_t LAST_IDX = rob_idx_t'(`BE_ROB_DEPTH - 1);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_o  <= '0;
      tail_o  <= '0;
      count_q <= '0;
    end else begin
      // pointers wrap at the last entry
      if (alloc_i) begin
        tail_o <= (tail_o == LAST_IDX) ? '0 : tail_o + 1'b1;
      end
      if (retire_i) begin
        head_o <= (head_o == LAST_IDX) ? '0 : head_o + 1'b1;
      end
      // alloc and retire together leave the count alone
      case ({alloc_i, retire_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  assign full_o  = (count_q == CNT_W'(`BE_ROB_DEPTH));
  assign empty_o = (count_q == '0);

endmodule

`default_nettype wire

// ==== rtl/rob.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_cfg.svh"

module rob (
  input  logic                clk_i,
  input  logic                rst_i,
  // allocation from issue
  input  logic                alloc_i,
  input  instr_pkg::reg_idx_t alloc_rd_i,
  output rob_pkg::rob_idx_t   tail_o,
  output logic                full_o,
  // alu result
  input  logic                res_valid_i,
  input  rob_pkg::rob_idx_t   res_tag_i,
  input  instr_pkg::word_t    res_value_i,
  // operand lookup
  input  rob_pkg::rob_idx_t   rs1_tag_i,
  input  rob_pkg::rob_idx_t   rs2_tag_i,
  output logic                rs1_done_o,
  output logic                rs2_done_o,
  output instr_pkg::word_t    rs1_value_o,
  output instr_pkg::word_t    rs2_value_o,
  // in-order retire
  commit_if.rob               commit
);
  import instr_pkg::*;
  import rob_pkg::*;

  // --------------------------------------------------
  // pointers and entry storage
  // --------------------------------------------------
  rob_idx_t                   head;
  logic                       empty;
  logic                       retire;
  logic [`BE_ROB_DEPTH-1:0]   done_q;
  reg_idx_t                   rd_q  [`BE_ROB_DEPTH];
  word_t                      val_q [`BE_ROB_DEPTH];

  rob_ptr_ctr u_rob_ptr_ctr (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .alloc_i (alloc_i),
    .retire_i(retire),
    .head_o  (head),
    .tail_o  (tail_o),
    .full_o  (full_o),
    .empty_o (empty)
  );

  // done flags, cleared on alloc and set by the alu
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_q <= '0;
    end else begin
      if (alloc_i) begin
        done_q[tail_o] <= 1'b0;
      end
      if (res_valid_i) begin
        done_q[res_tag_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      rd_q[tail_o] <= alloc_rd_i;
    end
    if (res_valid_i) begin
      val_q[res_tag_i] <= res_value_i;
    end
  end

  // --------------------------------------------------
  // lookup and commit
  // --------------------------------------------------
  assign rs1_done_o  = done_q[rs1_tag_i];
  assign rs2_done_o  = done_q[rs2_tag_i];
  assign rs1_value_o = val_q[rs1_tag_i];
  assign rs2_value_o = val_q[rs2_tag_i];

  // head retires as soon as its result is in
  assign retire       = done_q[head] && !empty;
  assign commit.valid = retire;
  assign commit.rd    = rd_q[head];
  assign commit.value = val_q[head];
  assign commit.tag   = head;

endmodule

`default_nettype wire

// ==== rtl/int_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_cfg.svh"

module int_regs (
  input  logic                clk_i,
  input  logic                rst_i,
  // new owner of a destination
  input  logic                set_busy_i,
  input  instr_pkg::reg_idx_t set_rd_i,
  input  rob_pkg::rob_idx_t   set_tag_i,
  // operand lookup
  input  instr_pkg::reg_idx_t rs1_idx_i,
  input  instr_pkg::reg_idx_t rs2_idx_i,
  output logic                rs1_busy_o,
  output logic                rs2_busy_o,
  output rob_pkg::rob_idx_t   rs1_tag_o,
  output rob_pkg::rob_idx_t   rs2_tag_o,
  output instr_pkg::word_t    rs1_value_o,
  output instr_pkg::word_t    rs2_value_o,
  // write from the rob
  commit_if.regs              commit
);
  import instr_pkg::*;
  import rob_pkg::*;

  word_t                  regs_q [`BE_REG_NUM];
  logic [`BE_REG_NUM-1:0] busy_q;
  rob_idx_t               tag_q  [`BE_REG_NUM];
  logic                   cm_wr;
  logic                   set_wr;

  // r0 is never written and never marked busy
  assign cm_wr  = commit.valid && (commit.rd != '0);
  assign set_wr = set_busy_i && (set_rd_i != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= '0;
      for (int i = 0; i < `BE_REG_NUM; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (cm_wr) begin
        regs_q[commit.rd] <= commit.value;
        // only the latest owner releases the register
        if (tag_q[commit.rd] == commit.tag) begin
          busy_q[commit.rd] <= 1'b0;
        end
      end
      // set after clear, same-cycle set wins
      if (set_wr) begin
        busy_q[set_rd_i] <= 1'b1;
      end
    end
  end

  // owner tags
  always_ff @(posedge clk_i) begin
    if (set_wr) begin
      tag_q[set_rd_i] <= set_tag_i;
    end
  end

  assign rs1_busy_o  = busy_q[rs1_idx_i];
  assign rs2_busy_o  = busy_q[rs2_idx_i];
  assign rs1_tag_o   = tag_q[rs1_idx_i];
  assign rs2_tag_o   = tag_q[rs2_idx_i];
  assign rs1_value_o = regs_q[rs1_idx_i];
  assign rs2_value_o = regs_q[rs2_idx_i];

endmodule

`default_nettype wire

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_cfg.svh"

module alu_unit (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               valid_i,
  input  instr_pkg::alu_op_t op_i,
  input  instr_pkg::word_t   a_i,
  input  instr_pkg::word_t   b_i,
  input  rob_pkg::rob_idx_t  tag_i,
  output logic               valid_o,
  output rob_pkg::rob_idx_t  tag_o,
  output instr_pkg::word_t   result_o
);
  import instr_pkg::*;
  import rob_pkg::*;

  localparam int LAT = `BE_ALU_LAT;

  word_t            res_d;
  logic [LAT-1:0]   vld_q;
  rob_idx_t         tag_q [LAT];
  word_t            res_q [LAT];

  // result computed ahead of the first stage
  always_comb begin
    case (op_i)
      ALU_ADD, ALU_ADDI: res_d = a_i + b_i;
      ALU_SUB:           res_d = a_i - b_i;
      ALU_AND:           res_d = a_i & b_i;
      ALU_OR:            res_d = a_i | b_i;
      ALU_XOR:           res_d = a_i ^ b_i;
      default:           res_d = '0;
    endcase
  end

  // valid shift chain
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= valid_i;
      for (int i = 1; i < LAT; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // tag and result follow the valid bits
  always_ff @(posedge clk_i) begin
    tag_q[0] <= tag_i;
    res_q[0] <= res_d;
    for (int i = 1; i < LAT; i++) begin
      tag_q[i] <= tag_q[i-1];
      res_q[i] <= res_q[i-1];
    end
  end

  assign valid_o  = vld_q[LAT-1];
  assign tag_o    = tag_q[LAT-1];
  assign result_o = res_q[LAT-1];

endmodule

`default_nettype wire

// ==== rtl/issue_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_fsm (
  input  logic                clk_i,
  input  logic                rst_i,
  // instruction strobe
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  instr_pkg::alu_op_t  instr_op_i,
  input  instr_pkg::reg_idx_t instr_rd_i,
  input  instr_pkg::reg_idx_t instr_rs1_i,
  input  instr_pkg::reg_idx_t instr_rs2_i,
  input  instr_pkg::word_t    instr_imm_i,
  // rob allocation
  input  logic                rob_full_i,
  input  rob_pkg::rob_idx_t   rob_tail_i,
  output logic                alloc_o,
  output instr_pkg::reg_idx_t alloc_rd_o,
  // register file and status lookup
  output instr_pkg::reg_idx_t rs1_idx_o,
  output instr_pkg::reg_idx_t rs2_idx_o,
  input  logic                rs1_busy_i,
  input  logic                rs2_busy_i,
  input  rob_pkg::rob_idx_t   rs1_tag_i,
  input  rob_pkg::rob_idx_t   rs2_tag_i,
  input  instr_pkg::word_t    rs1_value_i,
  input  instr_pkg::word_t    rs2_value_i,
  // rob lookup
  output rob_pkg::rob_idx_t   rob_rs1_tag_o,
  output rob_pkg::rob_idx_t   rob_rs2_tag_o,
  input  logic                rob_rs1_done_i,
  input  logic                rob_rs2_done_i,
  input  instr_pkg::word_t    rob_rs1_value_i,
  input  instr_pkg::word_t    rob_rs2_value_i,
  // register status update
  output logic                set_busy_o,
  output instr_pkg::reg_idx_t set_rd_o,
  output rob_pkg::rob_idx_t   set_tag_o,
  // alu dispatch
  output logic                ex_valid_o,
  output instr_pkg::alu_op_t  ex_op_o,
  output instr_pkg::word_t    ex_a_o,
  output instr_pkg::word_t    ex_b_o,
  output rob_pkg::rob_idx_t   ex_tag_o
);
  import instr_pkg::*;
  import rob_pkg::*;

  issue_state_t state_q;
  logic         live_q;
  logic         idle;
  logic         accept;
  logic         is_addi;
  alu_op_t      op_q;
  rob_idx_t     tag_q;
  logic         pend1_q;
  logic         pend2_q;
  rob_idx_t     src1_tag_q;
  rob_idx_t     src2_tag_q;
  word_t        a_q;
  word_t        b_q;
  logic         busy1;
  logic         busy2;
  logic         ok1;
  logic         ok2;
  word_t        base1;
  word_t        base2;
  word_t        val1;
  word_t        val2;

  // --------------------------------------------------
  // acceptance and allocation
  // --------------------------------------------------
  assign idle          = (state_q == ST_IDLE);
  assign is_addi       = (instr_op_i == ALU_ADDI);
  // live_q keeps ready low until reset is over
  assign instr_ready_o = live_q && idle && !rob_full_i;
  assign accept        = instr_valid_i && instr_ready_o;

  assign alloc_o    = accept;
  assign alloc_rd_o = instr_rd_i;
  assign set_busy_o = accept;
  assign set_rd_o   = instr_rd_i;
  assign set_tag_o  = rob_tail_i;
  assign rs1_idx_o  = instr_rs1_i;
  assign rs2_idx_o  = instr_rs2_i;

  // --------------------------------------------------
  // operand resolution
  // --------------------------------------------------
  // in idle the status table is read before our own set-busy lands
  // afterwards the latched producer tags are used
  always_comb begin
    if (idle) begin
      busy1         = rs1_busy_i;
      busy2         = rs2_busy_i && !is_addi;
      rob_rs1_tag_o = rs1_tag_i;
      rob_rs2_tag_o = rs2_tag_i;
      base1         = rs1_value_i;
      base2         = is_addi ? instr_imm_i : rs2_value_i;
    end else begin
      busy1         = pend1_q;
      busy2         = pend2_q;
      rob_rs1_tag_o = src1_tag_q;
      rob_rs2_tag_o = src2_tag_q;
      base1         = a_q;
      base2         = b_q;
    end
    // busy source is ready once its rob entry is done
    ok1  = !busy1 || rob_rs1_done_i;
    ok2  = !busy2 || rob_rs2_done_i;
    val1 = busy1 ? rob_rs1_value_i : base1;
    val2 = busy2 ? rob_rs2_value_i : base2;
  end

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      live_q  <= 1'b0;
      pend1_q <= 1'b0;
      pend2_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
      case (state_q)
        ST_IDLE: begin
          if (accept) begin
            pend1_q <= !ok1;
            pend2_q <= !ok2;
            state_q <= (ok1 && ok2) ? ST_DISPATCH : ST_WAIT_OPERANDS;
          end
        end
        ST_WAIT_OPERANDS: begin
          // recheck the rob every cycle
          pend1_q <= !ok1;
          pend2_q <= !ok2;
          if (ok1 && ok2) begin
            state_q <= ST_DISPATCH;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // operand and instruction payload
  always_ff @(posedge clk_i) begin
    if (accept || (state_q == ST_WAIT_OPERANDS)) begin
      a_q        <= val1;
      b_q        <= val2;
      src1_tag_q <= rob_rs1_tag_o;
      src2_tag_q <= rob_rs2_tag_o;
    end
    if (accept) begin
      op_q  <= instr_op_i;
      tag_q <= rob_tail_i;
    end
  end

  assign ex_valid_o = (state_q == ST_DISPATCH);
  assign ex_op_o    = op_q;
  assign ex_a_o     = a_q;
  assign ex_b_o     = b_q;
  assign ex_tag_o   = tag_q;

endmodule

`default_nettype wire

// ==== rtl/backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module backend (
  input  logic                clk_i,
  input  logic                rst_i,
  // instruction input
  input  logic                instr_valid_i,
  output logic                instr_ready_o,
  input  instr_pkg::alu_op_t  instr_op_i,
  input  instr_pkg::reg_idx_t instr_rd_i,
  input  instr_pkg::reg_idx_t instr_rs1_i,
  input  instr_pkg::reg_idx_t instr_rs2_i,
  input  instr_pkg::word_t    instr_imm_i,
  // in-order commit
  output logic                commit_valid_o,
  output instr_pkg::reg_idx_t commit_rd_o,
  output instr_pkg::word_t    commit_value_o
);

  // --------------------------------------------------
  // internal nets
  // --------------------------------------------------
  // issue and rob
  logic                il_rob_alloc;
  instr_pkg::reg_idx_t il_rob_alloc_rd;
  rob_pkg::rob_idx_t   rob_il_tail;
  logic                rob_il_full;
  rob_pkg::rob_idx_t   il_rob_rs1_tag;
  rob_pkg::rob_idx_t   il_rob_rs2_tag;
  logic                rob_il_rs1_done;
  logic                rob_il_rs2_done;
  instr_pkg::word_t    rob_il_rs1_value;
  instr_pkg::word_t    rob_il_rs2_value;

  // issue and register file
  instr_pkg::reg_idx_t il_rf_rs1_idx;
  instr_pkg::reg_idx_t il_rf_rs2_idx;
  logic                rf_il_rs1_busy;
  logic                rf_il_rs2_busy;
  rob_pkg::rob_idx_t   rf_il_rs1_tag;
  rob_pkg::rob_idx_t   rf_il_rs2_tag;
  instr_pkg::word_t    rf_il_rs1_value;
  instr_pkg::word_t    rf_il_rs2_value;
  logic                il_rf_set_busy;
  instr_pkg::reg_idx_t il_rf_set_rd;
  rob_pkg::rob_idx_t   il_rf_set_tag;

  // issue to alu, alu to rob
  logic                il_ex_valid;
  instr_pkg::alu_op_t  il_ex_op;
  instr_pkg::word_t    il_ex_a;
  instr_pkg::word_t    il_ex_b;
  rob_pkg::rob_idx_t   il_ex_tag;
  logic                ex_rob_valid;
  rob_pkg::rob_idx_t   ex_rob_tag;
  instr_pkg::word_t    ex_rob_value;

  // rob to registers and top outputs
  commit_if commit_bus ();

  // --------------------------------------------------
  // issue
  // --------------------------------------------------
  issue_fsm u_issue_fsm (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_valid_i  (instr_valid_i),
    .instr_ready_o  (instr_ready_o),
    .instr_op_i     (instr_op_i),
    .instr_rd_i     (instr_rd_i),
    .instr_rs1_i    (instr_rs1_i),
    .instr_rs2_i    (instr_rs2_i),
    .instr_imm_i    (instr_imm_i),
    .rob_full_i     (rob_il_full),
    .rob_tail_i     (rob_il_tail),
    .alloc_o        (il_rob_alloc),
    .alloc_rd_o     (il_rob_alloc_rd),
    .rs1_idx_o      (il_rf_rs1_idx),
    .rs2_idx_o      (il_rf_rs2_idx),
    .rs1_busy_i     (rf_il_rs1_busy),
    .rs2_busy_i     (rf_il_rs2_busy),
    .rs1_tag_i      (rf_il_rs1_tag),
    .rs2_tag_i      (rf_il_rs2_tag),
    .rs1_value_i    (rf_il_rs1_value),
    .rs2_value_i    (rf_il_rs2_value),
    .rob_rs1_tag_o  (il_rob_rs1_tag),
    .rob_rs2_tag_o  (il_rob_rs2_tag),
    .rob_rs1_done_i (rob_il_rs1_done),
    .rob_rs2_done_i (rob_il_rs2_done),
    .rob_rs1_value_i(rob_il_rs1_value),
    .rob_rs2_value_i(rob_il_rs2_value),
    .set_busy_o     (il_rf_set_busy),
    .set_rd_o       (il_rf_set_rd),
    .set_tag_o      (il_rf_set_tag),
    .ex_valid_o     (il_ex_valid),
    .ex_op_o        (il_ex_op),
    .ex_a_o         (il_ex_a),
    .ex_b_o         (il_ex_b),
    .ex_tag_o       (il_ex_tag)
  );

  // --------------------------------------------------
  // register file with status table
  // --------------------------------------------------
  int_regs u_int_regs (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .set_busy_i (il_rf_set_busy),
    .set_rd_i   (il_rf_set_rd),
    .set_tag_i  (il_rf_set_tag),
    .rs1_idx_i  (il_rf_rs1_idx),
    .rs2_idx_i  (il_rf_rs2_idx),
    .rs1_busy_o (rf_il_rs1_busy),
    .rs2_busy_o (rf_il_rs2_busy),
    .rs1_tag_o  (rf_il_rs1_tag),
    .rs2_tag_o  (rf_il_rs2_tag),
    .rs1_value_o(rf_il_rs1_value),
    .rs2_value_o(rf_il_rs2_value),
    .commit     (commit_bus.regs)
  );

  // --------------------------------------------------
  // execution, single alu writing the rob directly
  // --------------------------------------------------
  alu_unit u_alu_unit (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (il_ex_valid),
    .op_i    (il_ex_op),
    .a_i     (il_ex_a),
    .b_i     (il_ex_b),
    .tag_i   (il_ex_tag),
    .valid_o (ex_rob_valid),
    .tag_o   (ex_rob_tag),
    .result_o(ex_rob_value)
  );

  // --------------------------------------------------
  // reorder buffer
  // --------------------------------------------------
  rob u_rob (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .alloc_i    (il_rob_alloc),
    .alloc_rd_i (il_rob_alloc_rd),
    .tail_o     (rob_il_tail),
    .full_o     (rob_il_full),
    .res_valid_i(ex_rob_valid),
    .res_tag_i  (ex_rob_tag),
    .res_value_i(ex_rob_value),
    .rs1_tag_i  (il_rob_rs1_tag),
    .rs2_tag_i  (il_rob_rs2_tag),
    .rs1_done_o (rob_il_rs1_done),
    .rs2_done_o (rob_il_rs2_done),
    .rs1_value_o(rob_il_rs1_value),
    .rs2_value_o(rob_il_rs2_value),
    .commit     (commit_bus.rob)
  );

  // commit outputs tap the same bus
  assign commit_valid_o = commit_bus.valid;
  assign commit_rd_o    = commit_bus.rd;
  assign commit_value_o = commit_bus.value;

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter real PERIOD_NS  = 8.0,
  parameter int  RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  // reset held for RST_CYCLES rising edges
  // released on a falling edge like every other input
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/tb_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "backend_cfg.svh"

module tb_backend;
  import instr_pkg::*;

  localparam int RESET_LIMIT = 20;
  localparam int READY_LIMIT = 40;
  localparam int DRAIN_LIMIT = 200;

  logic     clk;
  logic     rst;
  logic     instr_valid;
  logic     instr_ready;
  alu_op_t  instr_op;
  reg_idx_t instr_rd;
  reg_idx_t instr_rs1;
  reg_idx_t instr_rs2;
  word_t    instr_imm;
  logic     commit_valid;
  reg_idx_t commit_rd;
  word_t    commit_value;

  // reference model, program order
  word_t    shadow [`BE_REG_NUM];
  reg_idx_t exp_rd_q [$];
  word_t    exp_val_q [$];

  int       seed;
  int       errors;
  int       accepted;
  int       committed;
  int       max_in_flight;
  logic     aborted;

  tb_clock #(.PERIOD_NS(8.0), .RST_CYCLES(5)) u_tb_clock (
    .clk_o(clk),
    .rst_o(rst)
  );

  backend UUT (
    .clk_i         (clk),
    .rst_i         (rst),
    .instr_valid_i (instr_valid),
    .instr_ready_o (instr_ready),
    .instr_op_i    (instr_op),
    .instr_rd_i    (instr_rd),
    .instr_rs1_i   (instr_rs1),
    .instr_rs2_i   (instr_rs2),
    .instr_imm_i   (instr_imm),
    .commit_valid_o(commit_valid),
    .commit_rd_o   (commit_rd),
    .commit_value_o(commit_value)
  );

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic word_t expected_result(alu_op_t op, word_t a, word_t b);
    case (op)
      ALU_ADD, ALU_ADDI: return a + b;
      ALU_SUB:           return a - b;
      ALU_AND:           return a & b;
      ALU_OR:            return a | b;
      ALU_XOR:           return a ^ b;
      default:           return '0;
    endcase
  endfunction

  // runs one accepted instruction on the shadow registers
  task automatic model_accept(alu_op_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                              word_t imm);
    word_t b;
    word_t res;
    b   = (op == ALU_ADDI) ? imm : shadow[rs2];
    res = expected_result(op, shadow[rs1], b);
    // r0 result still commits, but r0 stays zero
    if (rd != '0) begin
      shadow[rd] = res;
    end
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(res);
    accepted++;
  endtask

  // --------------------------------------------------
  // per-cycle checks at the falling edge
  // --------------------------------------------------
  task automatic check_commit();
    reg_idx_t exp_rd;
    word_t    exp_val;
    committed++;
    assert (exp_rd_q.size() != 0) else begin
      $display("unexpected commit at %0t with no instruction pending", $time);
      errors++;
    end
    if (exp_rd_q.size() != 0) begin
      exp_rd  = exp_rd_q.pop_front();
      exp_val = exp_val_q.pop_front();
      assert (commit_rd == exp_rd) else begin
        $display("CHECK FAILED at %0t: commit rd %0d, expected %0d",
                 $time, commit_rd, exp_rd);
        errors++;
      end
      assert (commit_value == exp_val) else begin
        $display("CHECK FAILED at %0t: commit value %h to r%0d, expected %h",
                 $time, commit_value, exp_rd, exp_val);
        errors++;
      end
    end
  endtask

  // accepted and committed both count edges up to this one
  task automatic tick();
    int in_flight;
    @(negedge clk);
    in_flight = accepted - committed;
    if (in_flight > max_in_flight) begin
      max_in_flight = in_flight;
    end
    assert (in_flight <= `BE_ROB_DEPTH) else begin
      $display("CHECK FAILED at %0t: %0d entries in flight", $time, in_flight);
      errors++;
    end
    if (in_flight == `BE_ROB_DEPTH) begin
      assert (!instr_ready) else begin
        $display("CHECK FAILED at %0t: ready high with a full ROB", $time);
        errors++;
      end
    end
    if (commit_valid) begin
      check_commit();
    end
  endtask

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  task automatic send_instr(alu_op_t op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                            word_t imm);
    int waited;
    waited = 0;
    if (aborted) begin
      return;
    end
    // ready does not depend on valid, stable here
    while (!aborted && !instr_ready && waited < READY_LIMIT) begin
      tick();
      waited++;
    end
    if (aborted) begin
      return;
    end
    if (!instr_ready) begin
      $display("timeout at %0t: instruction input never became ready", $time);
      errors++;
      aborted = 1'b1;
      return;
    end
    instr_valid = 1'b1;
    instr_op    = op;
    instr_rd    = rd;
    instr_rs1   = rs1;
    instr_rs2   = rs2;
    instr_imm   = imm;
    model_accept(op, rd, rs1, rs2, imm);
    // taken on the next rising edge
    tick();
    instr_valid = 1'b0;
    // issue leaves idle for at least one cycle after an accept
    assert (!instr_ready) else begin
      $display("CHECK FAILED at %0t: ready high right after an accept", $time);
      errors++;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (!aborted && committed != accepted && waited < DRAIN_LIMIT) begin
      tick();
      waited++;
    end
    if (!aborted && committed != accepted) begin
      $display("timeout at %0t: %0d instructions never committed",
               $time, accepted - committed);
      errors++;
      aborted = 1'b1;
    end
  endtask

  initial begin
    logic [31:0] rnd;
    int          waited;
    seed          = 21;
    errors        = 0;
    accepted      = 0;
    committed     = 0;
    max_in_flight = 0;
    aborted       = 1'b0;
    for (int i = 0; i < `BE_REG_NUM; i++) begin
      shadow[i] = '0;
    end
    instr_valid = 1'b0;
    instr_op    = ALU_ADD;
    instr_rd    = '0;
    instr_rs1   = '0;
    instr_rs2   = '0;
    instr_imm   = '0;

    // quiet outputs while in reset
    tick();
    assert (!instr_ready && !commit_valid) else begin
      $display("CHECK FAILED at %0t: outputs active during reset", $time);
      errors++;
    end
    // rst only moves on falling edges, sample it on rising ones
    waited = 0;
    while (rst && waited < RESET_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (rst) begin
      $display("reset was never released");
      errors++;
      aborted = 1'b1;
    end
    if (!aborted) begin
      tick();
      assert (instr_ready) else begin
        $display("CHECK FAILED at %0t: ready low after reset", $time);
        errors++;
      end
      assert (!commit_valid) else begin
        $display("CHECK FAILED at %0t: commit pulse right after reset", $time);
        errors++;
      end
    end

    // random mix, all ops, r0 included
    for (int i = 0; i < 24; i++) begin
      rnd = $random(seed);
      send_instr(alu_op_t'(3'(rnd[7:0] % 8'd6)), rnd[10:8], rnd[13:11], rnd[16:14],
                 rnd[31:16]);
    end
    wait_drain();

    // back-to-back chain, sources from the ROB
    send_instr(ALU_ADDI, 3'd1, 3'd0, 3'd0, 16'h0011);
    send_instr(ALU_ADD,  3'd2, 3'd1, 3'd1, 16'h0000);
    send_instr(ALU_SUB,  3'd3, 3'd2, 3'd1, 16'h0000);
    // rd equal to rs1 uses the older producer
    send_instr(ALU_XOR,  3'd2, 3'd2, 3'd3, 16'h0000);
    send_instr(ALU_AND,  3'd4, 3'd2, 3'd3, 16'h0000);
    wait_drain();

    // older results, now in the register file
    send_instr(ALU_OR,   3'd5, 3'd4, 3'd1, 16'h0000);
    send_instr(ALU_ADDI, 3'd6, 3'd3, 3'd0, 16'hfff0);
    wait_drain();

    // r0 write commits, r0 reads stay zero
    send_instr(ALU_ADDI, 3'd0, 3'd1, 3'd0, 16'h0100);
    send_instr(ALU_ADD,  3'd7, 3'd0, 3'd0, 16'h0000);
    send_instr(ALU_OR,   3'd6, 3'd0, 3'd2, 16'h0000);
    wait_drain();

    // dense dependencies on a few registers
    for (int i = 0; i < 32; i++) begin
      rnd = $random(seed);
      send_instr(alu_op_t'(3'(rnd[7:0] % 8'd6)), {1'b0, rnd[9:8]}, {1'b0, rnd[11:10]},
                 {1'b0, rnd[13:12]}, rnd[31:16]);
    end
    wait_drain();

    // drained, nothing left over
    assert (exp_rd_q.size() == 0) else begin
      $display("%0d expected commits never arrived", exp_rd_q.size());
      errors++;
    end
    assert (committed == accepted) else begin
      $display("commit count %0d differs from accepted count %0d", committed, accepted);
      errors++;
    end

    $display("errors: %0d, accepted: %0d, committed: %0d, max in flight: %0d",
             errors, accepted, committed, max_in_flight);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
rtl/instr_pkg.sv
rtl/rob_pkg.sv
rtl/commit_if.sv
rtl/rob_ptr_ctr.sv
rtl/rob.sv
rtl/int_regs.sv
rtl/alu_unit.sv
rtl/issue_fsm.sv
rtl/backend.sv
test/tb_clock.sv
test/tb_backend.sv

// ==== Makefile ====
# Verilator build and run for the backend testbench

VERILATOR ?= verilator
TOP       ?= tb_backend
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Done: no errors

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard rtl/*.sv test/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up on stdout
run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
